//--- src/digdar_bus_pkg.sv
// system bus address and data types, region select bits, scope register map
package digdar_bus_pkg;

   typedef logic [31:0] sys_addr_t;                    // byte address from host
   typedef logic [31:0] sys_data_t;                    // read and write data

   //----------------------------------------
   // region decode

   localparam int REGION_MSB = 22;                     // top region select bit
   localparam int REGION_LSB = 20;                     // 8 regions of 1 MB

   localparam logic [REGION_MSB-REGION_LSB:0] REGION_SCOPE = 3'd1;

   //----------------------------------------
   // scope register offsets inside the region

   localparam sys_addr_t REG_CTRL   = 32'h0000_0000;   // wr bit0 arms, rd state
   localparam sys_addr_t REG_THRESH = 32'h0000_0004;   // signed trigger level
   localparam sys_addr_t REG_DELAY  = 32'h0000_0008;   // samples after trigger
   localparam sys_addr_t REG_NEGATE = 32'h0000_000C;   // bit0 ch a, bit1 ch b

   // capture buffer window, one pair per 32-bit word
   localparam sys_addr_t BUF_BASE   = 32'h0001_0000;

endpackage

//--- src/digdar_sample_pkg.sv
// ADC width, sample type, sample pair union and capture state encoding
package digdar_sample_pkg;

   localparam int ADC_WIDTH = 14;                      // raw offset binary bits

   typedef logic signed [15:0] sample_t;               // sign extended sample

   typedef struct packed {
      sample_t a;                                      // ch a, upper half
      sample_t b;                                      // ch b, lower half
   } sample_pair_s;

   // the same word seen as a sample pair or as a bus word
   typedef union packed {
      sample_pair_s              pair;
      digdar_bus_pkg::sys_data_t raw;
   } sample_pair_u;

   typedef enum logic [2:0] {
      IDLE    = 3'd0,                                  // waiting for arm
      ARMED   = 3'd1,                                  // waiting for trigger
      DELAY   = 3'd2,                                  // trigger delay running
      CAPTURE = 3'd3,                                  // writing buffer
      DONE    = 3'd4                                   // buffer full
   } capture_state_e;

endpackage

//--- src/adc_frontend.sv
// ADC input registers, two's complement conversion, negation, channel B trigger
`timescale 1ns/100ps

module adc_frontend (
   input  logic                                         adc_clk,
   input  logic                                         rst_n_i,
   input  logic [digdar_sample_pkg::ADC_WIDTH-1:0]      adc_dat_a_i,  // offset binary
   input  logic [digdar_sample_pkg::ADC_WIDTH-1:0]      adc_dat_b_i,  // offset binary
   input  logic                                         neg_a_i,
   input  logic                                         neg_b_i,
   input  digdar_sample_pkg::sample_t                   thresh_i,     // trigger level
   output digdar_sample_pkg::sample_pair_u              pair_o,
   output logic                                         trig_o        // rising crossing
);

   localparam int ADC_W = digdar_sample_pkg::ADC_WIDTH;

   logic [ADC_W-1:0]                raw_a_r;           // first stage, as received
   logic [ADC_W-1:0]                raw_b_r;
   digdar_sample_pkg::sample_t      conv_a;            // converted, not yet registered
   digdar_sample_pkg::sample_t      conv_b;
   digdar_sample_pkg::sample_pair_u pair_r;

   // flip msb for two's complement, optional negate with saturation
   function automatic digdar_sample_pkg::sample_t convert(input logic [ADC_W-1:0] raw,
                                                          input logic neg);
      logic signed [ADC_W-1:0] tc;
      tc = {~raw[ADC_W-1], raw[ADC_W-2:0]};
      if (neg) begin
         if (tc == {1'b1, {(ADC_W-1){1'b0}}})
            tc = {1'b0, {(ADC_W-1){1'b1}}};          // -8192 has no positive twin
         else
            tc = -tc;
      end
      return digdar_sample_pkg::sample_t'(tc);         // sign extend
   endfunction

   always_ff @(posedge adc_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         raw_a_r <= '0;
         raw_b_r <= '0;
         pair_r  <= '0;
      end else begin
         raw_a_r         <= adc_dat_a_i;
         raw_b_r         <= adc_dat_b_i;
         pair_r.pair.a   <= conv_a;                    // out one edge after capture
         pair_r.pair.b   <= conv_b;
      end
   end

   assign conv_a = convert(raw_a_r, neg_a_i);
   assign conv_b = convert(raw_b_r, neg_b_i);

   // incoming b against the b now on pair_o, so the crossing sample comes next
   assign trig_o = (conv_b >= thresh_i) && (pair_r.pair.b < thresh_i);
   assign pair_o = pair_r;

endmodule

//--- src/sample_counter.sv
// loadable 16-bit down-counter holding at zero
`timescale 1ns/100ps

module sample_counter (
   input  logic        adc_clk,
   input  logic        rst_n_i,
   input  logic        load_i,                         // wins over count_en_i
   input  logic [15:0] load_value_i,
   input  logic        count_en_i,
   output logic [15:0] value_o,
   output logic        zero_o
);

   logic [15:0] cnt_r;

   always_ff @(posedge adc_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cnt_r <= '0;
      end else if (load_i) begin
         cnt_r <= load_value_i;
      end else if (count_en_i && (cnt_r != 16'd0)) begin
         cnt_r <= cnt_r - 16'd1;                       // stops at zero
      end
   end

   assign value_o = cnt_r;
   assign zero_o  = (cnt_r == 16'd0);

endmodule

//--- src/capture_fsm.sv
// arm, trigger delay, capture and done sequencing over the shared counter
`timescale 1ns/100ps

module capture_fsm #(
   parameter int CAPTURE_DEPTH = 256                   // power of two
) (
   input  logic                                  adc_clk,
   input  logic                                  rst_n_i,
   input  logic                                  arm_i,      // one cycle from bus
   input  logic                                  trig_i,
   input  logic [15:0]                           delay_i,
   input  logic                                  cnt_zero_i,
   input  logic [15:0]                           cnt_value_i,
   output logic                                  cnt_load_o,
   output logic [15:0]                           cnt_load_value_o,
   output logic                                  cnt_en_o,
   output logic                                  wr_en_o,
   output logic [$clog2(CAPTURE_DEPTH)-1:0]      wr_addr_o,
   output digdar_sample_pkg::capture_state_e     state_o
);

   localparam int AW = $clog2(CAPTURE_DEPTH);

   digdar_sample_pkg::capture_state_e state_r;
   digdar_sample_pkg::capture_state_e state_nxt;

   always_ff @(posedge adc_clk or negedge rst_n_i) begin
      if (!rst_n_i)
         state_r <= digdar_sample_pkg::IDLE;
      else
         state_r <= state_nxt;
   end

   always_comb begin
      state_nxt        = state_r;
      cnt_load_o       = 1'b0;
      cnt_load_value_o = 16'(CAPTURE_DEPTH - 1);       // capture length minus one
      case (state_r)
         digdar_sample_pkg::IDLE,
         digdar_sample_pkg::DONE: begin
            if (arm_i)
               state_nxt = digdar_sample_pkg::ARMED;
         end
         digdar_sample_pkg::ARMED: begin
            if (trig_i) begin
               cnt_load_o = 1'b1;
               if (delay_i == 16'd0) begin
                  state_nxt = digdar_sample_pkg::CAPTURE; // crossing sample is word 0
               end else begin
                  state_nxt        = digdar_sample_pkg::DELAY;
                  cnt_load_value_o = delay_i - 16'd1;  // zero flag ends the delay
               end
            end
         end
         digdar_sample_pkg::DELAY: begin
            if (cnt_zero_i) begin
               cnt_load_o = 1'b1;
               state_nxt  = digdar_sample_pkg::CAPTURE;
            end
         end
         digdar_sample_pkg::CAPTURE: begin
            if (cnt_zero_i)
               state_nxt = digdar_sample_pkg::DONE;    // last word written now
         end
         default: state_nxt = digdar_sample_pkg::IDLE;
      endcase
   end

   assign cnt_en_o  = (state_r == digdar_sample_pkg::DELAY) ||
                      (state_r == digdar_sample_pkg::CAPTURE);
   assign wr_en_o   = (state_r == digdar_sample_pkg::CAPTURE);
   assign wr_addr_o = AW'(CAPTURE_DEPTH - 1) - cnt_value_i[AW-1:0]; // from remaining count
   assign state_o   = state_r;

endmodule

//--- src/capture_buffer.sv
// dual-port sample pair memory, capture write port and registered bus read
`timescale 1ns/100ps

module capture_buffer #(
   parameter int CAPTURE_DEPTH = 256
) (
   input  logic                                 adc_clk,
   input  logic                                 wr_en_i,
   input  logic [$clog2(CAPTURE_DEPTH)-1:0]     wr_addr_i,
   input  digdar_sample_pkg::sample_pair_u      wr_data_i,
   input  logic [$clog2(CAPTURE_DEPTH)-1:0]     rd_addr_i,
   output digdar_sample_pkg::sample_pair_u      rd_data_o     // one cycle after rd_addr_i
);

   digdar_sample_pkg::sample_pair_u mem [CAPTURE_DEPTH];
   digdar_sample_pkg::sample_pair_u rd_data_r;

   always_ff @(posedge adc_clk) begin
      if (wr_en_i)
         mem[wr_addr_i] <= wr_data_i;
      rd_data_r <= mem[rd_addr_i];                     // read every cycle
   end

   assign rd_data_o = rd_data_r;

endmodule

//--- src/scope_bus_regs.sv
// system bus region decode, scope config registers, read mux, ack and err
`timescale 1ns/100ps

module scope_bus_regs #(
   parameter int CAPTURE_DEPTH = 256
) (
   input  logic                                 adc_clk,
   input  logic                                 rst_n_i,
   input  digdar_bus_pkg::sys_addr_t            sys_addr_i,
   input  digdar_bus_pkg::sys_data_t            sys_wdata_i,
   input  logic                                 sys_wen_i,     // one cycle strobe
   input  logic                                 sys_ren_i,     // one cycle strobe
   output digdar_bus_pkg::sys_data_t            sys_rdata_o,   // valid with ack
   output logic                                 sys_err_o,
   output logic                                 sys_ack_o,
   input  digdar_sample_pkg::capture_state_e    state_i,
   input  digdar_sample_pkg::sample_pair_u      rd_data_i,
   output logic [$clog2(CAPTURE_DEPTH)-1:0]     rd_addr_o,
   output digdar_sample_pkg::sample_t           thresh_o,
   output logic [15:0]                          delay_o,
   output logic                                 neg_a_o,
   output logic                                 neg_b_o,
   output logic                                 arm_o
);

   localparam int AW = $clog2(CAPTURE_DEPTH);
   localparam digdar_bus_pkg::sys_addr_t BUF_END =
      digdar_bus_pkg::BUF_BASE + digdar_bus_pkg::sys_addr_t'(4 * CAPTURE_DEPTH);

   //----------------------------------------
   // address decode

   digdar_bus_pkg::sys_addr_t  off;                   // offset inside region
   digdar_bus_pkg::sys_addr_t  buf_off;
   logic                       scope_sel;
   logic                       hit_ctrl, hit_thresh, hit_delay, hit_negate, hit_buf;
   logic                       wr_ok, rd_ok;
   digdar_bus_pkg::sys_data_t  reg_rdata;

   assign scope_sel  = (sys_addr_i[digdar_bus_pkg::REGION_MSB:digdar_bus_pkg::REGION_LSB] ==
                        digdar_bus_pkg::REGION_SCOPE);
   assign off        = digdar_bus_pkg::sys_addr_t'(sys_addr_i[digdar_bus_pkg::REGION_LSB-1:0]);
   assign buf_off    = off - digdar_bus_pkg::BUF_BASE;
   assign hit_ctrl   = (off == digdar_bus_pkg::REG_CTRL);
   assign hit_thresh = (off == digdar_bus_pkg::REG_THRESH);
   assign hit_delay  = (off == digdar_bus_pkg::REG_DELAY);
   assign hit_negate = (off == digdar_bus_pkg::REG_NEGATE);
   assign hit_buf    = (off >= digdar_bus_pkg::BUF_BASE) && (off < BUF_END);

   // buffer is read only, writes there get err
   assign wr_ok = sys_wen_i && scope_sel &&
                  (hit_ctrl || hit_thresh || hit_delay || hit_negate);
   assign rd_ok = sys_ren_i && scope_sel &&
                  (hit_ctrl || hit_thresh || hit_delay || hit_negate || hit_buf);

   assign rd_addr_o = buf_off[AW+1:2];                 // RAM reads during strobe cycle

   always_comb begin
      reg_rdata = '0;
      if (hit_ctrl)
         reg_rdata = {29'd0, state_i};                 // state code in bits 2..0
      else if (hit_thresh)
         reg_rdata = {16'd0, thresh_o};
      else if (hit_delay)
         reg_rdata = {16'd0, delay_o};
      else if (hit_negate)
         reg_rdata = {30'd0, neg_b_o, neg_a_o};
   end

   //----------------------------------------
   // registers and handshake

   logic                       ack_r, err_r, buf_sel_r;
   digdar_bus_pkg::sys_data_t  rdata_r;

   always_ff @(posedge adc_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_r     <= 1'b0;
         err_r     <= 1'b0;
         buf_sel_r <= 1'b0;
         rdata_r   <= '0;
         arm_o     <= 1'b0;
         thresh_o  <= '0;
         delay_o   <= '0;
         neg_a_o   <= 1'b0;
         neg_b_o   <= 1'b0;
      end else begin
         ack_r     <= sys_wen_i || sys_ren_i;          // always one cycle later
         err_r     <= (sys_wen_i || sys_ren_i) && !(wr_ok || rd_ok);
         buf_sel_r <= rd_ok && hit_buf;
         rdata_r   <= reg_rdata;
         arm_o     <= wr_ok && hit_ctrl && sys_wdata_i[0]; // single pulse
         if (wr_ok && hit_thresh)
            thresh_o <= digdar_sample_pkg::sample_t'(sys_wdata_i[15:0]);
         if (wr_ok && hit_delay)
            delay_o <= sys_wdata_i[15:0];
         if (wr_ok && hit_negate) begin
            neg_a_o <= sys_wdata_i[0];
            neg_b_o <= sys_wdata_i[1];
         end
      end
   end

   assign sys_ack_o   = ack_r;
   assign sys_err_o   = err_r;
   assign sys_rdata_o = buf_sel_r ? rd_data_i.raw : rdata_r; // RAM word or register
endmodule

//--- src/digdar_top.sv
// top level connecting front end, capture sequencer, counter, buffer and bus block
`timescale 1ns/100ps

module digdar_top #(
   parameter int CAPTURE_DEPTH = 256                   // buffer words, power of two
) (
   input  logic                                     adc_clk,
   input  logic                                     rst_n_i,
   input  logic [digdar_sample_pkg::ADC_WIDTH-1:0]  adc_dat_a_i,
   input  logic [digdar_sample_pkg::ADC_WIDTH-1:0]  adc_dat_b_i,
   input  digdar_bus_pkg::sys_addr_t                sys_addr_i,
   input  digdar_bus_pkg::sys_data_t                sys_wdata_i,
   input  logic                                     sys_wen_i,
   input  logic                                     sys_ren_i,
   output digdar_bus_pkg::sys_data_t                sys_rdata_o,
   output logic                                     sys_err_o,
   output logic                                     sys_ack_o
);

   localparam int AW = $clog2(CAPTURE_DEPTH);

   //----------------------------------------
   // internal nets

   digdar_sample_pkg::sample_pair_u    pair;           // converted a and b
   digdar_sample_pkg::sample_pair_u    rd_data;
   digdar_sample_pkg::sample_t         thresh;
   digdar_sample_pkg::capture_state_e  state;
   logic                               trig, arm, neg_a, neg_b;
   logic [15:0]                        delay, cnt_value, cnt_load_value;
   logic                               cnt_load, cnt_en, cnt_zero;
   logic                               wr_en;
   logic [AW-1:0]                      wr_addr, rd_addr;

   adc_frontend i_frontend (
      .adc_clk     (adc_clk),
      .rst_n_i     (rst_n_i),
      .adc_dat_a_i (adc_dat_a_i),
      .adc_dat_b_i (adc_dat_b_i),
      .neg_a_i     (neg_a),
      .neg_b_i     (neg_b),
      .thresh_i    (thresh),
      .pair_o      (pair),
      .trig_o      (trig)                              // radar trigger from ch b
   );

   capture_fsm #(.CAPTURE_DEPTH(CAPTURE_DEPTH)) i_capture_fsm (
      .adc_clk          (adc_clk),
      .rst_n_i          (rst_n_i),
      .arm_i            (arm),
      .trig_i           (trig),
      .delay_i          (delay),
      .cnt_zero_i       (cnt_zero),
      .cnt_value_i      (cnt_value),
      .cnt_load_o       (cnt_load),
      .cnt_load_value_o (cnt_load_value),
      .cnt_en_o         (cnt_en),
      .wr_en_o          (wr_en),
      .wr_addr_o        (wr_addr),
      .state_o          (state)
   );

   sample_counter i_counter (
      .adc_clk      (adc_clk),
      .rst_n_i      (rst_n_i),
      .load_i       (cnt_load),
      .load_value_i (cnt_load_value),
      .count_en_i   (cnt_en),
      .value_o      (cnt_value),
      .zero_o       (cnt_zero)
   );

   capture_buffer #(.CAPTURE_DEPTH(CAPTURE_DEPTH)) i_buffer (
      .adc_clk   (adc_clk),
      .wr_en_i   (wr_en),
      .wr_addr_i (wr_addr),
      .wr_data_i (pair),                               // live pair stream
      .rd_addr_i (rd_addr),
      .rd_data_o (rd_data)
   );

   scope_bus_regs #(.CAPTURE_DEPTH(CAPTURE_DEPTH)) i_scope_regs (
      .adc_clk     (adc_clk),
      .rst_n_i     (rst_n_i),
      .sys_addr_i  (sys_addr_i),
      .sys_wdata_i (sys_wdata_i),
      .sys_wen_i   (sys_wen_i),
      .sys_ren_i   (sys_ren_i),
      .sys_rdata_o (sys_rdata_o),
      .sys_err_o   (sys_err_o),
      .sys_ack_o   (sys_ack_o),
      .state_i     (state),
      .rd_data_i   (rd_data),
      .rd_addr_o   (rd_addr),
      .thresh_o    (thresh),
      .delay_o     (delay),
      .neg_a_o     (neg_a),
      .neg_b_o     (neg_b),
      .arm_o       (arm)
   );

endmodule

//--- tb/digdar_stim_model.sv
// ADC sample log converted by the front-end rule, and the channel B crossing search
`timescale 1ns/100ps

module digdar_stim_model #(
   parameter int LOG_DEPTH = 16384
) (
   input logic        adc_clk,
   input logic [13:0] adc_dat_a_i,                    // offset binary, as driven
   input logic [13:0] adc_dat_b_i,
   input logic        neg_a_i,
   input logic        neg_b_i
);

   logic signed [15:0] log_a [LOG_DEPTH];             // index = adc_clk edge number
   logic signed [15:0] log_b [LOG_DEPTH];
   int                 log_cnt = 0;

   // offset binary to signed, negation clipped at full scale
   function automatic logic signed [15:0] to_sample(input logic [13:0] raw, input logic neg);
      int v;
      v = int'(raw) - 8192;
      if (neg)
         v = (v == -8192) ? 8191 : -v;                // -8192 has no positive value
      return 16'(v);
   endfunction

   always @(posedge adc_clk) begin
      if (log_cnt < LOG_DEPTH) begin
         log_a[log_cnt] <= to_sample(adc_dat_a_i, neg_a_i);
         log_b[log_cnt] <= to_sample(adc_dat_b_i, neg_b_i);
         log_cnt        <= log_cnt + 1;
      end
   end

   // first rising crossing of ch b at or after index from, -1 if none
   function automatic int find_crossing(input int from, input logic signed [15:0] thresh);
      int i;
      find_crossing = -1;
      for (i = (from > 0) ? from : 1; i < log_cnt; i++) begin
         if (find_crossing < 0 && log_b[i] >= thresh && log_b[i-1] < thresh)
            find_crossing = i;
      end
   endfunction

endmodule

//--- tb/digdar_properties.sv
// bound checks on bus strobe to ack timing and on capture buffer writes
`timescale 1ns/100ps

module digdar_properties (
   input logic        adc_clk,
   input logic        rst_n_i,
   input logic        req_i,                          // wen or ren strobe
   input logic        ack_i,
   input logic        err_i,
   input logic        wr_en_i,                        // buffer write enable
   input logic        capture_i,                      // fsm in CAPTURE
   input logic [15:0] wr_addr_i
);

   int fail_cnt = 0;                                  // summed up by the testbench

   a_ack_next : assert property (@(posedge adc_clk) disable iff (!rst_n_i) req_i |=> ack_i)
      else begin
         $error("strobe not acked on the next edge");
         fail_cnt++;
      end

   a_err_ack : assert property (@(posedge adc_clk) disable iff (!rst_n_i) err_i |-> ack_i)
      else begin
         $error("err raised without ack");
         fail_cnt++;
      end

   // first CAPTURE cycle writes word 0
   a_wr_first : assert property (@(posedge adc_clk) disable iff (!rst_n_i)
                                 $rose(capture_i) |-> wr_en_i && (wr_addr_i == 16'd0))
      else begin
         $error("capture did not start writing at word 0");
         fail_cnt++;
      end

   // one pair per cycle, consecutive words
   a_wr_addr : assert property (@(posedge adc_clk) disable iff (!rst_n_i)
                                wr_en_i && $past(wr_en_i) |->
                                wr_addr_i == $past(wr_addr_i) + 16'd1)
      else begin
         $error("buffer write address did not step by one");
         fail_cnt++;
      end

endmodule

bind scope_bus_regs digdar_properties i_bus_props (
   .adc_clk (adc_clk), .rst_n_i (rst_n_i), .req_i (sys_wen_i || sys_ren_i),
   .ack_i (sys_ack_o), .err_i (sys_err_o),
   .wr_en_i (1'b0), .capture_i (1'b0), .wr_addr_i (16'd0)
);

bind capture_fsm digdar_properties i_fsm_props (
   .adc_clk (adc_clk), .rst_n_i (rst_n_i), .req_i (1'b0), .ack_i (1'b0), .err_i (1'b0),
   .wr_en_i (wr_en_o), .capture_i (state_o == digdar_sample_pkg::CAPTURE),
   .wr_addr_i (16'(wr_addr_o))
);

//--- tb/tb_digdar.sv
// testbench with clock, reset, random ADC stream, bus tasks, capture checks and report
`timescale 1ns/100ps

module tb_digdar;

   localparam int DEPTH = 256;

   logic                      adc_clk = 1'b0;
   logic                      rst_n_i = 1'b0;
   logic [13:0]               adc_dat_a_i = '0;
   logic [13:0]               adc_dat_b_i = '0;
   digdar_bus_pkg::sys_addr_t sys_addr_i = '0;
   digdar_bus_pkg::sys_data_t sys_wdata_i = '0;
   logic                      sys_wen_i = 1'b0;
   logic                      sys_ren_i = 1'b0;
   digdar_bus_pkg::sys_data_t sys_rdata_o;
   logic                      sys_err_o, sys_ack_o;

   int                 seed = 54;                     // config and delays
   int                 adc_seed = 54;                 // adc stream only
   int                 adc_mode = 0;                  // 0 noise, 1 crossing, 2 free
   logic signed [15:0] thresh = '0;                   // shadows of DUT registers
   logic               neg_a = 1'b0;
   logic               neg_b = 1'b0;
   int                 errors = 0;
   int                 timeouts = 0;
   int                 asserts;

   always #20 adc_clk = ~adc_clk;

   digdar_top #(.CAPTURE_DEPTH(DEPTH)) i_digdar_top (.*);

   digdar_stim_model i_model (
      .adc_clk (adc_clk), .adc_dat_a_i (adc_dat_a_i), .adc_dat_b_i (adc_dat_b_i),
      .neg_a_i (neg_a), .neg_b_i (neg_b)
   );

   // raw code that converts to v under the given negation
   function automatic logic [13:0] to_raw(input int v, input logic neg);
      int tc;
      tc = neg ? -v : v;
      return 14'(tc + 8192);
   endfunction

   function automatic digdar_bus_pkg::sys_addr_t scope_addr(input digdar_bus_pkg::sys_addr_t off);
      return {9'd0, digdar_bus_pkg::REGION_SCOPE, 20'd0} | off;
   endfunction

   //----------------------------------------
   // adc stream

   always @(posedge adc_clk) begin : adc_drive
      int r_a, r_b, span;
      #2;
      r_a = $random(adc_seed);
      r_b = $random(adc_seed);
      adc_dat_a_i = ((r_a & 15) == 0) ? 14'd0 : 14'(r_a);   // code 0 is -8192
      if (adc_mode == 0) begin
         span = int'(thresh) + 8191;                  // b kept below threshold
         adc_dat_b_i = to_raw(-8191 + int'($unsigned(r_b) % span), neg_b);
      end else if (adc_mode == 1) begin
         span = 8192 - int'(thresh);                  // single crossing sample
         adc_dat_b_i = to_raw(int'(thresh) + int'($unsigned(r_b) % span), neg_b);
         adc_mode = 2;
      end else begin
         adc_dat_b_i = ((r_b & 15) == 0) ? 14'd0 : 14'(r_b);
      end
   end

   //----------------------------------------
   // compare tasks

   task automatic check_pair(input string name, input digdar_sample_pkg::sample_pair_u got,
                             input digdar_sample_pkg::sample_pair_u exp);
      if (got.raw !== exp.raw) begin
         $display("** Error at %0t: %s got a=%0d b=%0d expected a=%0d b=%0d", $time, name,
                  got.pair.a, got.pair.b, exp.pair.a, exp.pair.b);
         errors++;
      end
   endtask

   task automatic check_word(input string name, input digdar_bus_pkg::sys_data_t got,
                             input digdar_bus_pkg::sys_data_t exp);
      if (got !== exp) begin
         $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("** Error at %0t: %s got %b expected %b", $time, name, got, exp);
         errors++;
      end
   endtask

   //----------------------------------------
   // bus access, strobe for one cycle then wait for ack

   task automatic bus_access(input digdar_bus_pkg::sys_addr_t addr,
                             input digdar_bus_pkg::sys_data_t wdata, input logic wr,
                             output digdar_bus_pkg::sys_data_t rdata, output logic err);
      int wait_cnt;
      @(posedge adc_clk);
      #2;
      sys_addr_i  = addr;
      sys_wdata_i = wdata;
      sys_wen_i   = wr;
      sys_ren_i   = !wr;
      @(posedge adc_clk);
      #2;
      sys_wen_i = 1'b0;
      sys_ren_i = 1'b0;
      wait_cnt  = 0;
      while (!sys_ack_o && wait_cnt < 16) begin
         @(posedge adc_clk);
         #2;
         wait_cnt++;
      end
      if (!sys_ack_o) begin
         $display("no ack from the DUT within 16 cycles for address %h", addr);
         timeouts++;
      end
      rdata = sys_rdata_o;
      err   = sys_err_o;
   endtask

   task automatic write_reg(input digdar_bus_pkg::sys_addr_t off,
                            input digdar_bus_pkg::sys_data_t data);
      digdar_bus_pkg::sys_data_t rd;
      logic err;
      bus_access(scope_addr(off), data, 1'b1, rd, err);
      check_flag("sys_err_o", err, 1'b0);
   endtask

   task automatic read_reg(input digdar_bus_pkg::sys_addr_t off,
                           output digdar_bus_pkg::sys_data_t data);
      logic err;
      bus_access(scope_addr(off), '0, 1'b0, data, err);
      check_flag("sys_err_o", err, 1'b0);
   endtask

   // configure, arm over noise, cross, optional arm while busy, compare the buffer
   task automatic run_capture(input logic na, input logic nb, input int delay, input logic rearm);
      digdar_bus_pkg::sys_data_t       rd;
      digdar_sample_pkg::sample_pair_u got, exp;
      int                              from, t, polls, k;
      @(negedge adc_clk);
      thresh   = 16'($random(seed) % 4096);
      neg_a    = na;
      neg_b    = nb;
      adc_mode = 0;
      write_reg(digdar_bus_pkg::REG_THRESH, {16'd0, thresh});
      write_reg(digdar_bus_pkg::REG_NEGATE, {30'd0, nb, na});
      write_reg(digdar_bus_pkg::REG_DELAY, 32'(delay));
      write_reg(digdar_bus_pkg::REG_CTRL, 32'd1);
      from = i_model.log_cnt;                         // first sample seen while ARMED
      repeat (3 + ($unsigned($random(seed)) % 8)) @(posedge adc_clk);
      @(negedge adc_clk);
      adc_mode = 1;
      if (rearm) begin
         repeat (2) @(posedge adc_clk);
         write_reg(digdar_bus_pkg::REG_CTRL, 32'd1);  // lands in DELAY or CAPTURE
      end
      rd    = '0;
      polls = 0;
      while (rd != 32'(digdar_sample_pkg::DONE) && polls < 400) begin
         read_reg(digdar_bus_pkg::REG_CTRL, rd);
         polls++;
      end
      if (rd != 32'(digdar_sample_pkg::DONE)) begin
         $display("capture did not reach DONE within %0d status reads", polls);
         timeouts++;
      end
      t = i_model.find_crossing(from, thresh);
      if (t < 0) begin
         $display("no threshold crossing found in the sample log after arming");
         errors++;
      end else begin
         for (k = 0; k < DEPTH; k++) begin
            read_reg(digdar_bus_pkg::BUF_BASE + 32'(4 * k), rd);
            got.raw    = rd;
            exp.pair.a = i_model.log_a[t + delay + k];
            exp.pair.b = i_model.log_b[t + delay + k];
            check_pair($sformatf("sys_rdata_o buffer word %0d", k), got, exp);
         end
      end
      read_reg(digdar_bus_pkg::REG_CTRL, rd);
      check_word("sys_rdata_o status after readout", rd, 32'(digdar_sample_pkg::DONE));
   endtask

   //----------------------------------------
   // main sequence

   initial begin
      digdar_bus_pkg::sys_data_t rd, wd;
      logic err;
      int r;
      repeat (10) @(posedge adc_clk);
      #2;
      rst_n_i = 1'b1;
      read_reg(digdar_bus_pkg::REG_CTRL, rd);
      check_word("sys_rdata_o status after reset", rd, 32'(digdar_sample_pkg::IDLE));
      for (r = 0; r < 8; r++) begin
         wd = $random(seed);
         write_reg(digdar_bus_pkg::REG_THRESH, wd);
         read_reg(digdar_bus_pkg::REG_THRESH, rd);
         check_word("sys_rdata_o REG_THRESH", rd, wd & 32'h0000_FFFF);
         write_reg(digdar_bus_pkg::REG_DELAY, wd ^ 32'h5A5A);
         read_reg(digdar_bus_pkg::REG_DELAY, rd);
         check_word("sys_rdata_o REG_DELAY", rd, (wd ^ 32'h5A5A) & 32'h0000_FFFF);
         write_reg(digdar_bus_pkg::REG_NEGATE, wd);
         read_reg(digdar_bus_pkg::REG_NEGATE, rd);
         check_word("sys_rdata_o REG_NEGATE", rd, wd & 32'h3);
      end
      for (r = 0; r < 8; r++) begin                   // every region but scope
         if (r != 1) begin
            bus_access({9'd0, 3'(r), 20'h00004}, $random(seed), 1'(r), rd, err);
            check_flag("sys_err_o other region", err, 1'b1);
         end
      end
      bus_access(scope_addr(32'h14), '0, 1'b0, rd, err);
      check_flag("sys_err_o unmapped offset", err, 1'b1);
      bus_access(scope_addr(digdar_bus_pkg::BUF_BASE + 32'(4 * DEPTH)), '0, 1'b0, rd, err);
      check_flag("sys_err_o past buffer end", err, 1'b1);
      run_capture(1'b0, 1'b0, 0, 1'b0);
      run_capture(1'b0, 1'b0, 1 + int'($unsigned($random(seed)) % 31), 1'b1);
      run_capture(1'b1, 1'b0, int'($unsigned($random(seed)) % 32), 1'b0);
      run_capture(1'b1, 1'b1, 1 + int'($unsigned($random(seed)) % 31), 1'b1);
      asserts = i_digdar_top.i_scope_regs.i_bus_props.fail_cnt +
                i_digdar_top.i_capture_fsm.i_fsm_props.fail_cnt;
      $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
               errors, timeouts, asserts);
      if (errors == 0 && timeouts == 0 && asserts == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

//--- digdar.f
src/digdar_bus_pkg.sv
src/digdar_sample_pkg.sv
src/adc_frontend.sv
src/sample_counter.sv
src/capture_fsm.sv
src/capture_buffer.sv
src/scope_bus_regs.sv
src/digdar_top.sv
tb/digdar_stim_model.sv
tb/digdar_properties.sv
tb/tb_digdar.sv

//--- Makefile
# Verilator build and run of the digdar capture testbench
VERILATOR ?= verilator
TOP       ?= tb_digdar
FILELIST  ?= digdar.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= test passed

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, search $(LOG) for the pass line"
	@echo "make clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
